// ==== list.f ====
+incdir+.
exec_pkg.sv
alu_logic_shift.sv
alu_arith.sv
hilo_unit.sv
exec_unit.sv
tb_clock.sv
tb_exec_unit.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the exec_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_exec_unit \
	-Mdir obj_dir -o tb_exec_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_exec_unit 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb_exec_unit.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module tb_exec_unit;

	import exec_pkg::*;

	localparam int DW          = `EXEC_DATA_W;
	localparam int AW          = `EXEC_REG_ADDR_W;
	localparam int MAX_DELAY   = 5;
	localparam int N_RAND      = 40;
	localparam int N_MUL       = 12;
	localparam int N_CHAIN     = 4;
	localparam int CHAIN_LEN   = 4;
	localparam int N_SPAN      = 3;
	localparam int SPAN_OPS    = 12;
	localparam int HOLD_CYC    = 20;
	localparam int TOTAL_OPS   = 2 + (N_RAND + 6) + (N_RAND + 8) + (N_MUL * 3 + 6) +
		(2 + N_CHAIN * (CHAIN_LEN + 2)) + N_SPAN * SPAN_OPS;
	localparam int WATCHDOG_NS = TOTAL_OPS * (2 + MAX_DELAY) * 4 +
		(5 + N_SPAN * HOLD_CYC + 200) * 4;

	localparam data_t ALL_ONES = {DW{1'b1}};
	localparam data_t MAX_POS  = {1'b0, {(DW-1){1'b1}}};
	localparam data_t MIN_NEG  = {1'b1, {(DW-1){1'b0}}};

	typedef struct packed {
		logic [AW-1:0] wd;
		logic          wreg;
		data_t         wdata;
		logic          ov;
	} beat_t;

	logic          clk;
	logic          reset_i    = 1'b1;
	logic          op_valid_i = 1'b0;
	exec_op_e      op_i       = OP_NOP;
	data_t         reg1_i     = '0;
	data_t         reg2_i     = '0;
	logic [AW-1:0] wd_i       = '0;
	logic          wreg_i     = 1'b0;
	logic          credit_i   = 1'b0;
	logic          stall_o;
	logic          res_valid_o;
	logic [AW-1:0] res_wd_o;
	logic          res_wreg_o;
	data_t         res_wdata_o;
	logic          res_ov_o;

	// expected beats in issue order, with the test that issued them
	beat_t exp_q[$];
	string name_q[$];
	beat_t exp_beat;
	string exp_name;
	string cur_test     = "reset";
	data_t hi_m         = '0;
	data_t lo_m         = '0;
	logic  hold_credits = 1'b0;
	int    accepted         = 0;
	int    beats_seen       = 0;
	int    credits_returned = 0;
	int    credit_wait      = 0;

	tb_clock u_clock (
		.clk_o (clk)
	);

	exec_unit u_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.op_valid_i  (op_valid_i),
		.op_i        (op_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.wd_i        (wd_i),
		.wreg_i      (wreg_i),
		.stall_o     (stall_o),
		.res_valid_o (res_valid_o),
		.res_wd_o    (res_wd_o),
		.res_wreg_o  (res_wreg_o),
		.res_wdata_o (res_wdata_o),
		.res_ov_o    (res_ov_o),
		.credit_i    (credit_i)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [2*DW-1:0] product64(input logic sgn, input data_t a, input data_t b);
		logic [2*DW-1:0] ea;
		logic [2*DW-1:0] eb;
		ea = sgn ? {{DW{a[DW-1]}}, a} : {{DW{1'b0}}, a};
		eb = sgn ? {{DW{b[DW-1]}}, b} : {{DW{1'b0}}, b};
		return ea * eb;
	endfunction

	// run of equal bits from the msb down
	function automatic data_t lead_count(input data_t v, input logic bit_val);
		int n;
		n = 0;
		while ((n < DW) && (v[DW-1-n] == bit_val))
			n++;
		return data_t'(n);
	endfunction

	function automatic beat_t expected_beat(input exec_op_e op, input data_t a, input data_t b,
		input logic [AW-1:0] wd, input logic wr, input data_t hi, input data_t lo);
		beat_t                    e;
		logic                     has_dest;
		logic [`EXEC_SHAMT_W-1:0] sh;
		logic [2*DW-1:0]          prod;
		sh       = a[`EXEC_SHAMT_W-1:0];
		prod     = product64(1'b1, a, b);
		e.wd     = wd;
		e.wdata  = '0;
		e.ov     = 1'b0;
		has_dest = 1'b1;
		case (op)
			OP_OR:   e.wdata = a | b;
			OP_AND:  e.wdata = a & b;
			OP_NOR:  e.wdata = ~(a | b);
			OP_XOR:  e.wdata = a ^ b;
			OP_SLL:  e.wdata = b << sh;
			OP_SRL:  e.wdata = b >> sh;
			// sign bit copied into the vacated high bits
			OP_SRA:  e.wdata = (b >> sh) | (b[DW-1] ? ~(ALL_ONES >> sh) : '0);
			OP_ADD, OP_ADDU:
			begin
				e.wdata = a + b;
				e.ov = (op == OP_ADD) && (a[DW-1] == b[DW-1]) && (e.wdata[DW-1] != a[DW-1]);
			end
			OP_SUB, OP_SUBU:
			begin
				e.wdata = a - b;
				e.ov = (op == OP_SUB) && (a[DW-1] != b[DW-1]) && (e.wdata[DW-1] != a[DW-1]);
			end
			OP_SLT:  e.wdata = data_t'($signed(a) < $signed(b));
			OP_SLTU: e.wdata = data_t'(a < b);
			OP_CLZ:  e.wdata = lead_count(a, 1'b0);
			OP_CLO:  e.wdata = lead_count(a, 1'b1);
			OP_MUL:  e.wdata = prod[DW-1:0];
			OP_MFHI: e.wdata = hi;
			OP_MFLO: e.wdata = lo;
			default: has_dest = 1'b0;
		endcase
		// no register write on overflow or hi/lo only ops
		e.wreg = wr && has_dest && !e.ov;
		return e;
	endfunction

	task automatic update_hilo(input exec_op_e op, input data_t a, input data_t b);
		logic [2*DW-1:0] acc;
		acc = {hi_m, lo_m};
		case (op)
			OP_MULT:  acc = product64(1'b1, a, b);
			OP_MULTU: acc = product64(1'b0, a, b);
			OP_MADD:  acc = acc + product64(1'b1, a, b);
			OP_MADDU: acc = acc + product64(1'b0, a, b);
			OP_MSUB:  acc = acc - product64(1'b1, a, b);
			OP_MSUBU: acc = acc - product64(1'b0, a, b);
			OP_MTHI:  acc[2*DW-1:DW] = a;
			OP_MTLO:  acc[DW-1:0] = a;
			default:  acc = {hi_m, lo_m};
		endcase
		{hi_m, lo_m} = acc;
	endtask

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_field(input string test, input string field, input data_t exp,
		input data_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: %s expected %h actual %h", test, field, exp, act);
			abort_run();
		end
	endtask

	// corner values a third of the time
	function automatic data_t rand_word();
		case ($urandom_range(11, 0))
			0:       return '0;
			1:       return ALL_ONES;
			2:       return MAX_POS;
			3:       return MIN_NEG;
			default: return data_t'($urandom());
		endcase
	endfunction

	function automatic exec_op_e random_op(input exec_op_e first, input exec_op_e last);
		return exec_op_e'($urandom_range(int'(last), int'(first)));
	endfunction

	// called just after a rising edge, returns just after the accept edge
	task automatic issue(input exec_op_e op, input data_t a, input data_t b, input logic wr);
		logic [AW-1:0] wd;
		wd = AW'($urandom());
		op_valid_i <= 1'b1;
		op_i       <= op;
		reg1_i     <= a;
		reg2_i     <= b;
		wd_i       <= wd;
		wreg_i     <= wr;
		@(negedge clk);
		while (stall_o)
			@(negedge clk);
		exp_q.push_back(expected_beat(op, a, b, wd, wr, hi_m, lo_m));
		name_q.push_back(cur_test);
		update_hilo(op, a, b);
		accepted++;
		@(posedge clk);
		// accumulate holds the unit in its second cycle
		if ((op == OP_MADD) || (op == OP_MADDU) || (op == OP_MSUB) || (op == OP_MSUBU))
		begin
			op_valid_i <= 1'b0;
			@(negedge clk);
			if (!stall_o)
			begin
				$display("%s: stall_o low in the second cycle of an accumulate", cur_test);
				abort_run();
			end
			@(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h5a8c));
		repeat (5)
			@(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_field(cur_test, "res_valid_o", '0, data_t'(res_valid_o));
		check_field(cur_test, "stall_o", '0, data_t'(stall_o));
		@(posedge clk);
		issue(OP_MFHI, rand_word(), rand_word(), 1'b1);
		issue(OP_MFLO, rand_word(), rand_word(), 1'b1);

		cur_test = "logic_shift";
		repeat (N_RAND)
			issue(random_op(OP_OR, OP_SRA), rand_word(), rand_word(), $urandom_range(7, 0) != 0);
		issue(OP_SLL, data_t'(0), rand_word(), 1'b1);
		issue(OP_SLL, data_t'(31), rand_word(), 1'b1);
		issue(OP_SRL, ALL_ONES & ~data_t'(31), rand_word(), 1'b1);
		issue(OP_SRL, data_t'(31), ALL_ONES, 1'b1);
		issue(OP_SRA, data_t'(31), rand_word() | MIN_NEG, 1'b1);
		issue(OP_SRA, data_t'(4), rand_word() | MIN_NEG, 1'b1);

		cur_test = "arith";
		repeat (N_RAND)
			issue(random_op(OP_ADD, OP_CLO), rand_word(), rand_word(), $urandom_range(7, 0) != 0);
		issue(OP_ADD, MAX_POS, data_t'(1), 1'b1);
		issue(OP_SUB, MIN_NEG, data_t'(1), 1'b1);
		issue(OP_ADDU, MAX_POS, data_t'(1), 1'b1);
		issue(OP_SUBU, MIN_NEG, data_t'(1), 1'b1);
		issue(OP_CLZ, '0, rand_word(), 1'b1);
		issue(OP_CLZ, ALL_ONES, rand_word(), 1'b1);
		issue(OP_CLO, '0, rand_word(), 1'b1);
		issue(OP_CLO, ALL_ONES, rand_word(), 1'b1);

		cur_test = "mul_move";
		repeat (N_MUL)
		begin
			issue(random_op(OP_MULT, OP_MUL), rand_word(), rand_word(), 1'b1);
			issue(OP_MFHI, rand_word(), rand_word(), 1'b1);
			issue(OP_MFLO, rand_word(), rand_word(), 1'b1);
		end
		issue(OP_MTHI, rand_word(), rand_word(), 1'b1);
		issue(OP_MFHI, rand_word(), rand_word(), 1'b1);
		issue(OP_MFLO, rand_word(), rand_word(), 1'b1);
		issue(OP_MTLO, rand_word(), rand_word(), 1'b1);
		issue(OP_MFHI, rand_word(), rand_word(), 1'b1);
		issue(OP_MFLO, rand_word(), rand_word(), 1'b1);

		cur_test = "accumulate";
		issue(OP_MTHI, rand_word(), rand_word(), 1'b1);
		issue(OP_MTLO, rand_word(), rand_word(), 1'b1);
		repeat (N_CHAIN)
		begin
			repeat (CHAIN_LEN)
				issue(random_op(OP_MADD, OP_MSUBU), rand_word(), rand_word(), 1'b1);
			issue(OP_MFHI, rand_word(), rand_word(), 1'b1);
			issue(OP_MFLO, rand_word(), rand_word(), 1'b1);
		end

		// consumer stops freeing beats for a while
		cur_test = "back_pressure";
		repeat (N_SPAN)
		begin
			hold_credits <= 1'b1;
			fork
				begin
					repeat (HOLD_CYC)
						@(posedge clk);
					hold_credits <= 1'b0;
				end
				repeat (SPAN_OPS)
					issue(random_op(OP_OR, OP_CLO), rand_word(), rand_word(), 1'b1);
			join
		end

		op_valid_i <= 1'b0;
		op_i       <= OP_NOP;
		while ((beats_seen != accepted) || (credits_returned != beats_seen))
			@(posedge clk);
		// quiet window, a late extra beat meets an empty queue
		repeat (4 * (MAX_DELAY + 2))
			@(posedge clk);
		$display("test passed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// scoreboard, consumer and watchdog
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!reset_i && res_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("result beat arrived with no accepted operation outstanding");
				abort_run();
			end
			else
			begin
				exp_beat = exp_q.pop_front();
				exp_name = name_q.pop_front();
				check_field(exp_name, "res_wd_o", data_t'(exp_beat.wd), data_t'(res_wd_o));
				check_field(exp_name, "res_wreg_o", data_t'(exp_beat.wreg), data_t'(res_wreg_o));
				check_field(exp_name, "res_wdata_o", exp_beat.wdata, res_wdata_o);
				check_field(exp_name, "res_ov_o", data_t'(exp_beat.ov), data_t'(res_ov_o));
				beats_seen++;
				if (beats_seen - credits_returned > `EXEC_CREDITS)
				begin
					$display("more beats in flight than the consumer can buffer");
					abort_run();
				end
			end
		end
	end

	// one credit per freed beat, spaced by a random delay
	always @(posedge clk)
	begin
		if (credit_i)
			credits_returned = credits_returned + 1;
		credit_i <= 1'b0;
		if (!reset_i && !hold_credits && (beats_seen > credits_returned))
		begin
			if (credit_wait == 0)
			begin
				credit_i    <= 1'b1;
				credit_wait = $urandom_range(MAX_DELAY, 0);
			end
			else
				credit_wait = credit_wait - 1;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, %0d beats still expected",
			WATCHDOG_NS, exp_q.size());
		abort_run();
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD_NS = 4
) (
	output logic clk_o
);

	logic clk = 1'b0;

	assign clk_o = clk;

	// free running, toggles every half period
	always
	begin
		#(PERIOD_NS / 2);
		clk = ~clk;
	end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_unit (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                op_valid_i,
	input  exec_pkg::exec_op_e  op_i,
	input  exec_pkg::data_t     reg1_i,
	input  exec_pkg::data_t     reg2_i,
	input  exec_pkg::reg_addr_t wd_i,
	input  logic                wreg_i,
	output logic                stall_o,
	output logic                res_valid_o,
	output exec_pkg::reg_addr_t res_wd_o,
	output logic                res_wreg_o,
	output exec_pkg::data_t     res_wdata_o,
	output logic                res_ov_o,
	input  logic                credit_i
);

	import exec_pkg::*;

	logic       accept;
	logic       is_acc;
	logic       acc_busy;
	logic       beat_load;
	credit_t    credit_cnt;
	reg_addr_t  acc_wd;
	res_class_e res_class;
	data_t      logic_res;
	data_t      shift_res;
	data_t      arith_res;
	logic       arith_ov;
	data_t      mul_lo;
	data_t      move_res;
	data_t      sel_wdata;
	logic       sel_wreg;

	alu_logic_shift u_logic_shift (
		.op_i        (op_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res)
	);

	alu_arith u_arith (
		.op_i        (op_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.arith_res_o (arith_res),
		.ov_o        (arith_ov)
	);

	hilo_unit u_hilo (
		.clk        (clk),
		.reset_i    (reset_i),
		.accept_i   (accept),
		.op_i       (op_i),
		.reg1_i     (reg1_i),
		.reg2_i     (reg2_i),
		.mul_lo_o   (mul_lo),
		.move_res_o (move_res),
		.busy_o     (acc_busy)
	);

	//////////////////////////////////////////////////////////////////////
	// issue and credits
	//////////////////////////////////////////////////////////////////////

	assign is_acc = (op_i == OP_MADD) || (op_i == OP_MADDU) ||
		(op_i == OP_MSUB) || (op_i == OP_MSUBU);

	assign stall_o = (credit_cnt == '0) || acc_busy;
	assign accept  = op_valid_i && !stall_o;

	// accumulate beats leave from the second cycle
	assign beat_load = (accept && !is_acc) || acc_busy;

	// one credit spent per registered beat
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			credit_cnt <= credit_t'(`EXEC_CREDITS);
		end
		else
		begin
			credit_cnt <= credit_cnt + credit_t'(credit_i) - credit_t'(beat_load);
		end
	end

	// destination held across the accumulate
	always_ff @(posedge clk)
	begin
		if (accept && is_acc)
		begin
			acc_wd <= wd_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// result select and beat register
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op_i)
			OP_OR, OP_AND, OP_NOR, OP_XOR:     res_class = RES_LOGIC;
			OP_SLL, OP_SRL, OP_SRA:            res_class = RES_SHIFT;
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
			OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:   res_class = RES_ARITH;
			OP_MUL:                            res_class = RES_MUL;
			OP_MFHI, OP_MFLO:                  res_class = RES_MOVE;
			default:                           res_class = RES_NONE;
		endcase
	end

	always_comb
	begin
		case (res_class)
			RES_LOGIC: sel_wdata = logic_res;
			RES_SHIFT: sel_wdata = shift_res;
			RES_ARITH: sel_wdata = arith_res;
			RES_MUL:   sel_wdata = mul_lo;
			RES_MOVE:  sel_wdata = move_res;
			default:   sel_wdata = '0;
		endcase
	end

	// hi/lo only ops never write, overflow kills the write
	assign sel_wreg = wreg_i && (res_class != RES_NONE) && !arith_ov;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			res_valid_o <= 1'b0;
			res_wreg_o  <= 1'b0;
			res_ov_o    <= 1'b0;
		end
		else
		begin
			res_valid_o <= beat_load;
			if (acc_busy)
			begin
				res_wreg_o <= 1'b0;
				res_ov_o   <= 1'b0;
			end
			else if (beat_load)
			begin
				res_wreg_o <= sel_wreg;
				res_ov_o   <= arith_ov;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (acc_busy)
		begin
			res_wd_o    <= acc_wd;
			res_wdata_o <= '0;
		end
		else if (beat_load)
		begin
			res_wd_o    <= wd_i;
			res_wdata_o <= sel_wdata;
		end
	end

endmodule

// ==== hilo_unit.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module hilo_unit (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               accept_i,
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::data_t    reg1_i,
	input  exec_pkg::data_t    reg2_i,
	output exec_pkg::data_t    mul_lo_o,
	output exec_pkg::data_t    move_res_o,
	output logic               busy_o
);

	import exec_pkg::*;

	localparam int MSB = `EXEC_DATA_W - 1;

	// accumulate sequencer
	typedef enum logic {
		ST_IDLE,
		ST_ACC
	} acc_state_e;

	acc_state_e state;
	data_t      hi;
	data_t      lo;
	dword_t     acc_tmp;

	logic   is_signed;
	logic   is_madd;
	logic   is_msub;
	data_t  mag1;
	data_t  mag2;
	dword_t mag_prod;
	dword_t product;

	//////////////////////////////////////////////////////////////////////
	// multiplier
	//////////////////////////////////////////////////////////////////////

	assign is_signed = (op_i == OP_MULT) || (op_i == OP_MUL) ||
		(op_i == OP_MADD) || (op_i == OP_MSUB);
	assign is_madd = (op_i == OP_MADD) || (op_i == OP_MADDU);
	assign is_msub = (op_i == OP_MSUB) || (op_i == OP_MSUBU);

	// signed ops multiply magnitudes
	assign mag1 = (is_signed && reg1_i[MSB]) ? data_t'(-reg1_i) : reg1_i;
	assign mag2 = (is_signed && reg2_i[MSB]) ? data_t'(-reg2_i) : reg2_i;
	assign mag_prod = dword_t'(mag1) * dword_t'(mag2);

	// sign fixed up afterwards
	assign product = (is_signed && (reg1_i[MSB] ^ reg2_i[MSB])) ?
		dword_t'(-mag_prod) : mag_prod;

	assign mul_lo_o = product[MSB:0];

	always_comb
	begin
		case (op_i)
			OP_MFHI: move_res_o = hi;
			OP_MFLO: move_res_o = lo;
			default: move_res_o = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// madd / msub sequencing
	//////////////////////////////////////////////////////////////////////

	assign busy_o = (state == ST_ACC);

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state <= ST_IDLE;
		end
		else if (state == ST_IDLE)
		begin
			if (accept_i && (is_madd || is_msub))
			begin
				state <= ST_ACC;
			end
		end
		else
		begin
			state <= ST_IDLE;
		end
	end

	// first cycle keeps the product, negated for msub
	always_ff @(posedge clk)
	begin
		if (accept_i && (is_madd || is_msub))
		begin
			acc_tmp <= is_msub ? dword_t'(-product) : product;
		end
	end

	// hi/lo, accumulate in second cycle
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (state == ST_ACC)
		begin
			{hi, lo} <= {hi, lo} + acc_tmp;
		end
		else if (accept_i)
		begin
			case (op_i)
				OP_MULT, OP_MULTU: {hi, lo} <= product;
				OP_MTHI:           hi <= reg1_i;
				OP_MTLO:           lo <= reg1_i;
				default:
				begin
				end
			endcase
		end
	end

endmodule

// ==== alu_arith.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module alu_arith (
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::data_t    reg1_i,
	input  exec_pkg::data_t    reg2_i,
	output exec_pkg::data_t    arith_res_o,
	output logic               ov_o
);

	import exec_pkg::*;

	localparam int MSB   = `EXEC_DATA_W - 1;
	localparam int CNT_W = $clog2(`EXEC_DATA_W + 1);

	logic             is_sub;
	data_t            opnd2;
	logic             opnd2_sign;
	data_t            sum;
	logic             slt_res;
	logic             sltu_res;
	data_t            scan;
	logic [CNT_W-1:0] lead_cnt;
	logic             lead_done;

	//////////////////////////////////////////////////////////////////////
	// adder
	//////////////////////////////////////////////////////////////////////

	// slt reuses the difference
	assign is_sub = (op_i == OP_SUB) || (op_i == OP_SUBU) || (op_i == OP_SLT);
	assign opnd2  = is_sub ? data_t'(~reg2_i + 1'b1) : reg2_i;
	assign sum    = reg1_i + opnd2;

	// effective sign of the second term, also right for the most negative value
	assign opnd2_sign = is_sub ? ~reg2_i[MSB] : reg2_i[MSB];

	// signed overflow, only add and sub trap it
	assign ov_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) &&
		(reg1_i[MSB] == opnd2_sign) && (sum[MSB] != reg1_i[MSB]);

	// opposite signs decide directly, else the difference sign
	assign slt_res  = (reg1_i[MSB] != reg2_i[MSB]) ? reg1_i[MSB] : sum[MSB];
	assign sltu_res = reg1_i < reg2_i;

	//////////////////////////////////////////////////////////////////////
	// leading zero / one count
	//////////////////////////////////////////////////////////////////////

	// clo counts zeros of the inverted word
	assign scan = (op_i == OP_CLO) ? ~reg1_i : reg1_i;

	always_comb
	begin
		lead_cnt  = '0;
		lead_done = 1'b0;
		for (int i = MSB; i >= 0; i--)
		begin
			if (!lead_done)
			begin
				if (scan[i])
				begin
					lead_done = 1'b1;
				end
				else
				begin
					lead_cnt = lead_cnt + 1'b1;
				end
			end
		end
	end

	// result select
	always_comb
	begin
		case (op_i)
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res_o = sum;
			OP_SLT:                           arith_res_o = data_t'(slt_res);
			OP_SLTU:                          arith_res_o = data_t'(sltu_res);
			OP_CLZ, OP_CLO:                   arith_res_o = data_t'(lead_cnt);
			default:                          arith_res_o = '0;
		endcase
	end

endmodule

// ==== alu_logic_shift.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module alu_logic_shift (
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::data_t    reg1_i,
	input  exec_pkg::data_t    reg2_i,
	output exec_pkg::data_t    logic_res_o,
	output exec_pkg::data_t    shift_res_o
);

	import exec_pkg::*;

	logic [`EXEC_SHAMT_W-1:0] shamt;

	// shift amount from the first operand
	assign shamt = reg1_i[`EXEC_SHAMT_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// bitwise logic
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op_i)
			OP_OR:   logic_res_o = reg1_i | reg2_i;
			OP_AND:  logic_res_o = reg1_i & reg2_i;
			OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
			OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
			default: logic_res_o = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// barrel shifts
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op_i)
			OP_SLL:  shift_res_o = reg2_i << shamt;
			OP_SRL:  shift_res_o = reg2_i >> shamt;
			// sign fill from bit 31 of the shifted operand
			OP_SRA:  shift_res_o = data_t'($signed(reg2_i) >>> shamt);
			default: shift_res_o = '0;
		endcase
	end

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

`include "exec_settings.svh"

	// word, product and register number
	typedef logic [`EXEC_DATA_W-1:0]     data_t;
	typedef logic [2*`EXEC_DATA_W-1:0]   dword_t;
	typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;

	// wide enough to hold the full credit count
	typedef logic [$clog2(`EXEC_CREDITS+1)-1:0] credit_t;

	// operations handled by the execute unit
	typedef enum logic [4:0] {
		OP_NOP,
		OP_OR,
		OP_AND,
		OP_NOR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_SUBU,
		OP_SLT,
		OP_SLTU,
		OP_CLZ,
		OP_CLO,
		OP_MULT,
		OP_MULTU,
		OP_MUL,
		OP_MADD,
		OP_MADDU,
		OP_MSUB,
		OP_MSUBU,
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO
	} exec_op_e;

	// where the write data of a beat comes from
	typedef enum logic [2:0] {
		RES_NONE,
		RES_LOGIC,
		RES_SHIFT,
		RES_ARITH,
		RES_MUL,
		RES_MOVE
	} res_class_e;

endpackage

// ==== exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// operand and result word
`define EXEC_DATA_W 32

// destination register number
`define EXEC_REG_ADDR_W 5

// low bits of the first operand used as shift amount
`define EXEC_SHAMT_W 5

//////////////////////////////////////////////////////////////////////
// result port flow control
//////////////////////////////////////////////////////////////////////

// beats the consumer can buffer, any value of 1 or more
`define EXEC_CREDITS 2

`endif
